//--- design/rs_defines.svh
`ifndef RS_DEFINES_SVH
`define RS_DEFINES_SVH

//------------------------------------------------------------
// code parameters
//------------------------------------------------------------

`define RS_N          15   // code word length, symbols
`define RS_CHECK      4    // check symbols = syndromes = locator taps
`define RS_M          4    // bits per symbol

// field and generator
`define RS_IRRPOL     19   // x^4 + x + 1
`define RS_GENSTART   0    // exponent of first root
`define RS_ROOTSPACE  1    // exponent step between roots

`endif

//--- design/rs_pkg.sv
`include "rs_defines.svh"

package rs_pkg;

  //------------------------------------------------------------
  // types
  //------------------------------------------------------------

  typedef logic [`RS_M-1:0] data_t;              // gf symbol, also address and count
  typedef logic             ptr_t;               // buffer bank select
  typedef data_t            rom_t [0:(1 << `RS_M)-1];

  localparam int gf_n_max = (1 << `RS_M) - 1;    // multiplicative group order

  //------------------------------------------------------------
  // field helpers
  //------------------------------------------------------------

  // power -> element table, alpha^i at index i
  function automatic rom_t gf_alpha_to(input int irrpol);
    rom_t           tbl;
    logic [`RS_M:0] v;
    logic [`RS_M:0] poly;
    poly = irrpol[`RS_M:0];
    v    = 1;
    for (int i = 0; i < gf_n_max; i++) begin
      tbl[i] = v[`RS_M-1:0];
      v      = v << 1;
      if (v[`RS_M]) begin
        v = v ^ poly;                            // reduce by field polynomial
      end
    end
    tbl[gf_n_max] = '0;                          // unused slot, zero has no log
    return tbl;
  endfunction

  // shift and add multiply, reduced on the fly
  function automatic data_t gf_mult(input data_t a, input data_t b);
    data_t          prod;
    logic [`RS_M:0] aa;
    logic [`RS_M:0] poly;
    poly = `RS_IRRPOL;
    prod = '0;
    aa   = {1'b0, a};
    for (int i = 0; i < `RS_M; i++) begin
      if (b[i]) begin
        prod = prod ^ aa[`RS_M-1:0];
      end
      aa = aa << 1;
      if (aa[`RS_M]) begin
        aa = aa ^ poly;
      end
    end
    return prod;
  endfunction

  // a times alpha^power, power taken modulo the group order
  function automatic data_t gf_mult_const(input data_t a, input int power);
    rom_t tbl;
    tbl = gf_alpha_to(`RS_IRRPOL);
    return gf_mult(a, tbl[power % gf_n_max]);
  endfunction

endpackage

//--- design/rs_eras_syndrome_count.sv
`timescale 1ns/1ps
`include "rs_defines.svh"

module rs_eras_syndrome_count (
  input  logic          iclk,
  input  logic          ireset,
  input  logic          sop,
  input  logic          val,
  input  logic          eop,
  input  rs_pkg::data_t dat,
  input  logic          eras,
  output logic          wr_en,
  output rs_pkg::ptr_t  wr_bank,
  output rs_pkg::data_t wr_addr,
  output rs_pkg::data_t wr_data,
  output logic          syn_val,
  output rs_pkg::ptr_t  syn_ptr,
  output rs_pkg::data_t syn       [`RS_CHECK],
  output rs_pkg::data_t eras_poly [`RS_CHECK],
  output rs_pkg::data_t eras_num
);

  import rs_pkg::*;

  // position of symbol 0 and the inverse-root step
  localparam data_t first_pos = gf_mult_const(data_t'(1), `RS_ROOTSPACE * (`RS_N - 1));
  localparam int    step_pow  = gf_n_max - (`RS_ROOTSPACE % gf_n_max);

  data_t syn_acc [`RS_CHECK];   // running syndromes
  data_t loc_acc [`RS_CHECK];   // running locator, coeffs 1..check
  data_t cnt_acc;
  data_t pos;                   // root position of current symbol
  data_t e_pos;
  logic  val_d;
  logic  sop_d;
  logic  eop_d;
  logic  eras_d;
  logic  last_d;                // frame done, locator settling

  //------------------------------------------------------------
  // syndromes, horner per root
  //------------------------------------------------------------
  always_ff @(posedge iclk) begin
    if (val) begin
      for (int i = 0; i < `RS_CHECK; i++) begin
        syn_acc[i] <= sop ? dat :
          (dat ^ gf_mult_const(syn_acc[i], (`RS_GENSTART + i) * `RS_ROOTSPACE));
      end
      pos <= sop ? first_pos : gf_mult_const(pos, step_pow); // walk positions down
    end
  end

  //------------------------------------------------------------
  // control pipe and buffer write strobe
  //------------------------------------------------------------
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      val_d   <= 1'b0;
      sop_d   <= 1'b0;
      eop_d   <= 1'b0;
      eras_d  <= 1'b0;
      last_d  <= 1'b0;
      syn_val <= 1'b0;
      wr_en   <= 1'b0;
      wr_bank <= '0;
    end else begin
      val_d   <= val;
      sop_d   <= sop;
      eop_d   <= eop;
      eras_d  <= eras;
      last_d  <= val_d & eop_d;
      syn_val <= last_d;          // locator final by now
      wr_en   <= val;
      if (val && sop) begin
        wr_bank <= ~wr_bank;      // new frame, other bank
      end
    end
  end

  always_ff @(posedge iclk) begin
    if (val) begin
      wr_data <= dat;
      wr_addr <= sop ? '0 : wr_addr + 1'b1;
    end
  end

  //------------------------------------------------------------
  // erasure locator, one cycle behind data
  //------------------------------------------------------------
  assign e_pos = eras_d ? pos : '0;  // zero term leaves poly unchanged

  always_ff @(posedge iclk) begin
    if (val_d) begin
      loc_acc[0] <= sop_d ? e_pos : (loc_acc[0] ^ e_pos);
      for (int i = 1; i < `RS_CHECK; i++) begin
        loc_acc[i] <= sop_d ? '0 : (loc_acc[i] ^ gf_mult(loc_acc[i-1], e_pos));
      end
      cnt_acc <= sop_d ? data_t'(eras_d) : (cnt_acc + data_t'(eras_d));
    end
  end

  // result snapshot, survives a back to back frame
  always_ff @(posedge iclk) begin
    if (val_d && eop_d) begin
      syn     <= syn_acc;
      syn_ptr <= wr_bank;         // still the bank just filled
    end
    if (last_d) begin
      eras_poly <= loc_acc;
      eras_num  <= cnt_acc;
    end
  end

endmodule

//--- design/rs_frame_buffer.sv
`timescale 1ns/1ps
`include "rs_defines.svh"

module rs_frame_buffer (
  input  logic          iclk,
  input  logic          wr_en,
  input  rs_pkg::ptr_t  wr_bank,
  input  rs_pkg::data_t wr_addr,
  input  rs_pkg::data_t wr_data,
  input  rs_pkg::ptr_t  rd_bank,
  input  rs_pkg::data_t rd_addr,
  output rs_pkg::data_t rd_data
);

  import rs_pkg::*;

  //------------------------------------------------------------
  // two banks of one frame each
  //------------------------------------------------------------
  data_t mem [0:1][0:`RS_N-1];

  // write side, engine owns it
  always_ff @(posedge iclk) begin
    if (wr_en) begin
      mem[wr_bank][wr_addr] <= wr_data;
    end
  end

  // read side
  // registered, data one cycle after address
  always_ff @(posedge iclk) begin
    rd_data <= mem[rd_bank][rd_addr];
  end

endmodule

//--- design/rs_syndrome_handoff.sv
`timescale 1ns/1ps
`include "rs_defines.svh"

module rs_syndrome_handoff (
  input  logic          iclk,
  input  logic          ireset,
  input  logic          syn_val,
  input  rs_pkg::ptr_t  syn_ptr,
  input  rs_pkg::data_t syn       [`RS_CHECK],
  input  rs_pkg::data_t eras_poly [`RS_CHECK],
  input  rs_pkg::data_t eras_num,
  input  logic          res_ack,
  output logic          res_req,
  output rs_pkg::ptr_t  res_ptr,
  output rs_pkg::data_t res_syn       [`RS_CHECK],
  output rs_pkg::data_t res_eras_poly [`RS_CHECK],
  output rs_pkg::data_t res_eras_num,
  output rs_pkg::data_t drop_cnt
);

  import rs_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_req,     // req high, waiting for ack
    st_wait     // req low, waiting for ack to fall
  } state_t;

  state_t state;
  logic   take;

  assign take = syn_val && (state == st_idle);

  //------------------------------------------------------------
  // four-phase FSM
  //------------------------------------------------------------
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      state    <= st_idle;
      res_req  <= 1'b0;
      drop_cnt <= '0;
    end else begin
      case (state)
        st_idle : if (syn_val) begin
          state   <= st_req;
          res_req <= 1'b1;
        end
        st_req  : if (res_ack) begin
          state   <= st_wait;
          res_req <= 1'b0;
        end
        default : if (!res_ack) state <= st_idle;
      endcase
      if (syn_val && state != st_idle && drop_cnt != '1) begin
        drop_cnt <= drop_cnt + 1'b1;  // busy, frame lost, saturates
      end
    end
  end

  // holding regs, only loaded from idle
  always_ff @(posedge iclk) begin
    if (take) begin
      res_ptr       <= syn_ptr;
      res_syn       <= syn;
      res_eras_poly <= eras_poly;
      res_eras_num  <= eras_num;
    end
  end

endmodule

//--- design/rs_decoder_frontend.sv
`timescale 1ns/1ps
`include "rs_defines.svh"

module rs_decoder_frontend (
  input  logic          iclk,
  input  logic          ireset,
  input  logic          sop,
  input  logic          val,
  input  logic          eop,
  input  rs_pkg::data_t dat,
  input  logic          eras,
  input  logic          res_ack,
  input  rs_pkg::data_t rd_addr,
  output logic          res_req,
  output rs_pkg::ptr_t  res_ptr,
  output rs_pkg::data_t res_syn       [`RS_CHECK],
  output rs_pkg::data_t res_eras_poly [`RS_CHECK],
  output rs_pkg::data_t res_eras_num,
  output rs_pkg::data_t drop_cnt,
  output rs_pkg::data_t rd_data
);

  import rs_pkg::*;

  //------------------------------------------------------------
  // engine -> buffer, engine -> handoff
  //------------------------------------------------------------
  logic  wr_en;
  ptr_t  wr_bank;
  data_t wr_addr;
  data_t wr_data;
  logic  syn_val;
  ptr_t  syn_ptr;
  data_t syn       [`RS_CHECK];
  data_t eras_poly [`RS_CHECK];
  data_t eras_num;

  rs_eras_syndrome_count u_engine (
    .iclk      (iclk),
    .ireset    (ireset),
    .sop       (sop),
    .val       (val),
    .eop       (eop),
    .dat       (dat),
    .eras      (eras),
    .wr_en     (wr_en),
    .wr_bank   (wr_bank),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data),
    .syn_val   (syn_val),
    .syn_ptr   (syn_ptr),
    .syn       (syn),
    .eras_poly (eras_poly),
    .eras_num  (eras_num)
  );

  rs_frame_buffer u_buffer (
    .iclk    (iclk),
    .wr_en   (wr_en),
    .wr_bank (wr_bank),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .rd_bank (res_ptr),   // consumer reads the bank on offer
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  rs_syndrome_handoff u_handoff (
    .iclk          (iclk),
    .ireset        (ireset),
    .syn_val       (syn_val),
    .syn_ptr       (syn_ptr),
    .syn           (syn),
    .eras_poly     (eras_poly),
    .eras_num      (eras_num),
    .res_ack       (res_ack),
    .res_req       (res_req),
    .res_ptr       (res_ptr),
    .res_syn       (res_syn),
    .res_eras_poly (res_eras_poly),
    .res_eras_num  (res_eras_num),
    .drop_cnt      (drop_cnt)
  );

endmodule

//--- verif/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int period_ns = 40
) (
  output logic iclk
);

  // free running, 50% duty
  initial begin
    iclk = 1'b0;
    forever begin
      #(period_ns / 2.0) iclk = ~iclk;
    end
  end

endmodule

//--- verif/rs_frontend_checker.sv
`timescale 1ns/1ps
`include "rs_defines.svh"

module rs_frontend_checker (
  input  logic          iclk,
  input  logic          ireset,
  input  logic          sop,
  input  logic          val,
  input  logic          eop,
  input  rs_pkg::data_t dat,
  input  logic          eras,
  input  logic          res_ack,
  input  rs_pkg::data_t rd_addr,
  input  logic          res_req,
  input  rs_pkg::ptr_t  res_ptr,
  input  rs_pkg::data_t res_syn       [`RS_CHECK],
  input  rs_pkg::data_t res_eras_poly [`RS_CHECK],
  input  rs_pkg::data_t res_eras_num,
  input  rs_pkg::data_t drop_cnt,
  input  rs_pkg::data_t rd_data,
  input  logic          run_done,
  output int            err_cnt,
  output logic          report_done
);

  import rs_pkg::*;

  typedef struct packed {
    logic [`RS_N-1:0][`RS_M-1:0]     sym;  // frame as sent
    logic [`RS_CHECK-1:0][`RS_M-1:0] syn;
    logic [`RS_CHECK-1:0][`RS_M-1:0] loc;  // locator coeffs 1..check
    logic [`RS_M-1:0]                num;
    logic                            ptr;
  } result_t;

  typedef enum {m_idle, m_req, m_wait} hs_t;

  result_t    exp_q [$];      // frames whose result is still due
  result_t    cur;            // result on offer
  hs_t        hs;
  data_t      cap_sym  [`RS_N];
  logic       cap_eras [`RS_N];
  int         cap_idx;
  ptr_t       bank;
  logic [2:0] eop_sr;         // eop sample to syn_val seen
  data_t      drop_model;
  logic       req_d;
  logic       ack_d;
  logic       rd_pend;
  data_t      rd_exp;
  int         n_frames;
  int         n_delivered;
  int         n_dropped;
  int         n_reads;

  initial begin
    err_cnt     = 0;
    report_done = 1'b0;
    n_frames    = 0;
    n_delivered = 0;
    n_dropped   = 0;
    n_reads     = 0;
  end

  //------------------------------------------------------------
  // reference model from straight sums and products
  //------------------------------------------------------------
  function automatic result_t model_result(input ptr_t fbank);
    result_t r;
    rom_t    tbl;
    data_t   loc [0:`RS_CHECK];
    data_t   xj;
    int      pw;
    tbl    = gf_alpha_to(`RS_IRRPOL);
    r      = '0;
    loc[0] = data_t'(1);
    for (int k = 1; k <= `RS_CHECK; k++) begin
      loc[k] = '0;
    end
    for (int j = 0; j < `RS_N; j++) begin
      r.sym[j] = cap_sym[j];
      for (int i = 0; i < `RS_CHECK; i++) begin
        pw       = ((`RS_GENSTART + i) * `RS_ROOTSPACE * (`RS_N - 1 - j)) % gf_n_max;
        r.syn[i] = r.syn[i] ^ gf_mult(cap_sym[j], tbl[pw]);
      end
      if (cap_eras[j]) begin
        xj = tbl[(`RS_ROOTSPACE * (`RS_N - 1 - j)) % gf_n_max];  // erased position
        for (int k = `RS_CHECK; k > 0; k--) begin
          loc[k] = loc[k] ^ gf_mult(loc[k-1], xj);  // times (1 + xj X) truncated
        end
        r.num = r.num + 1'b1;
      end
    end
    for (int k = 1; k <= `RS_CHECK; k++) begin
      r.loc[k-1] = loc[k];
    end
    r.ptr = fbank;
    return r;
  endfunction

  task automatic value_error(input string name, input logic [7:0] got, input logic [7:0] exp);
    err_cnt++;
    $display("CHECK FAILED at %0t: %s is %0h, expected %0h", $time, name, got, exp);
  endtask

  task automatic plain_error(input string what);
    err_cnt++;
    $display("error at %0t: %s", $time, what);
  endtask

  // whole result set against the one on offer
  task automatic compare_outputs();
    if (res_ptr !== cur.ptr) value_error("res_ptr", res_ptr, cur.ptr);
    if (res_eras_num !== cur.num) value_error("res_eras_num", res_eras_num, cur.num);
    for (int i = 0; i < `RS_CHECK; i++) begin
      if (res_syn[i] !== cur.syn[i]) begin
        value_error($sformatf("res_syn[%0d]", i), res_syn[i], cur.syn[i]);
      end
      if (res_eras_poly[i] !== cur.loc[i]) begin
        value_error($sformatf("res_eras_poly[%0d]", i), res_eras_poly[i], cur.loc[i]);
      end
    end
  endtask

  //------------------------------------------------------------
  // per-edge compare on pre-edge values
  //------------------------------------------------------------
  always @(posedge iclk) begin
    logic arrive;
    if (ireset) begin
      hs         = m_idle;
      cap_idx    = 0;
      bank       = '0;
      eop_sr     = '0;
      drop_model = '0;
      req_d      = 1'b0;
      ack_d      = 1'b0;
      rd_pend    = 1'b0;
      exp_q.delete();
    end else begin
      if (rd_pend && rd_data !== rd_exp) value_error("rd_data", rd_data, rd_exp);
      rd_pend = 1'b0;
      if (res_req !== (hs == m_req)) value_error("res_req", res_req, hs == m_req);
      if (drop_cnt !== drop_model) value_error("drop_cnt", drop_cnt, drop_model);
      if (res_req && !req_d) begin
        n_delivered++;
        if (ack_d) plain_error("req went high while ack was still high");
      end
      if ((res_req || res_ack) && hs != m_idle) begin
        compare_outputs();                   // also holds them stable
        if (res_req && rd_addr < `RS_N) begin
          rd_exp  = cur.sym[rd_addr];        // registered read due next edge
          rd_pend = 1'b1;
          n_reads++;
        end
      end
      req_d = res_req;
      ack_d = res_ack;

      // handoff replay
      arrive = eop_sr[2];
      if (arrive && exp_q.size() == 0) begin
        plain_error("a result was due but no frame had been captured");
        arrive = 1'b0;
      end
      if (arrive && hs != m_idle) begin
        exp_q.delete(0);                     // busy so the frame is lost
        n_dropped++;
        if (drop_model != '1) drop_model = drop_model + 1'b1;
      end
      case (hs)
        m_idle : if (arrive) begin
          cur = exp_q.pop_front();
          hs  = m_req;
        end
        m_req  : if (res_ack) hs = m_wait;
        default: if (!res_ack) hs = m_idle;
      endcase

      // input capture
      eop_sr = {eop_sr[1:0], val & eop};
      if (val) begin
        if (sop) begin
          cap_idx = 0;
          bank    = ~bank;                   // engine flips bank on sop
        end
        if (cap_idx < `RS_N) begin
          cap_sym[cap_idx]  = dat;
          cap_eras[cap_idx] = eras;
        end
        cap_idx++;
        if (eop) begin
          exp_q.push_back(model_result(bank));
          n_frames++;
        end
      end

      // closing report
      if (run_done && !report_done) begin
        if (exp_q.size() != 0) plain_error("frames still waiting for a result at the end");
        if (n_delivered + n_dropped != n_frames) begin
          plain_error("delivered and dropped frames do not add up to the frames sent");
        end
        if (n_delivered == 0) plain_error("no result was ever delivered");
        $display("errors %0d, frames %0d, delivered %0d, dropped %0d, read samples %0d",
                 err_cnt, n_frames, n_delivered, n_dropped, n_reads);
        report_done = 1'b1;
      end
    end
  end

endmodule

//--- verif/rs_frontend_tb.sv
`timescale 1ns/1ps
`include "rs_defines.svh"

module rs_frontend_tb;

  import rs_pkg::*;

  localparam int n_frames   = 40;
  localparam int max_gap    = 40;   // idle cycles between frames
  localparam int period_ns  = 40;
  // frames x (frame + gap + consumer slot) cycles, margin of two
  localparam int timeout_ns = 2 * n_frames * (`RS_N + max_gap + 40) * period_ns;

  logic  iclk;
  logic  ireset;
  logic  sop;
  logic  val;
  logic  eop;
  logic  eras;
  data_t dat;
  logic  res_ack;
  data_t rd_addr;
  logic  res_req;
  ptr_t  res_ptr;
  data_t res_syn       [`RS_CHECK];
  data_t res_eras_poly [`RS_CHECK];
  data_t res_eras_num;
  data_t drop_cnt;
  data_t rd_data;
  logic  run_done;
  logic  report_done;
  int    err_cnt;
  ptr_t  bank;                      // bank the next frame lands in

  tb_clock_gen #(.period_ns(period_ns)) u_clk (.iclk(iclk));

  rs_decoder_frontend u_dut (
    .iclk          (iclk),
    .ireset        (ireset),
    .sop           (sop),
    .val           (val),
    .eop           (eop),
    .dat           (dat),
    .eras          (eras),
    .res_ack       (res_ack),
    .rd_addr       (rd_addr),
    .res_req       (res_req),
    .res_ptr       (res_ptr),
    .res_syn       (res_syn),
    .res_eras_poly (res_eras_poly),
    .res_eras_num  (res_eras_num),
    .drop_cnt      (drop_cnt),
    .rd_data       (rd_data)
  );

  rs_frontend_checker u_chk (
    .iclk          (iclk),
    .ireset        (ireset),
    .sop           (sop),
    .val           (val),
    .eop           (eop),
    .dat           (dat),
    .eras          (eras),
    .res_ack       (res_ack),
    .rd_addr       (rd_addr),
    .res_req       (res_req),
    .res_ptr       (res_ptr),
    .res_syn       (res_syn),
    .res_eras_poly (res_eras_poly),
    .res_eras_num  (res_eras_num),
    .drop_cnt      (drop_cnt),
    .rd_data       (rd_data),
    .run_done      (run_done),
    .err_cnt       (err_cnt),
    .report_done   (report_done)
  );

  // one code word, a symbol per falling edge
  task automatic send_frame();
    for (int j = 0; j < `RS_N; j++) begin
      val  = 1'b1;
      sop  = (j == 0);
      eop  = (j == `RS_N - 1);
      dat  = data_t'($urandom);
      eras = (($urandom % 5) == 0);  // about 1 in 5 erased
      @(negedge iclk);
    end
    val  = 1'b0;
    sop  = 1'b0;
    eop  = 1'b0;
    eras = 1'b0;
  endtask

  //------------------------------------------------------------
  // stimulus
  //------------------------------------------------------------
  initial begin
    int gap;
    ireset   = 1'b1;
    sop      = 1'b0;
    val      = 1'b0;
    eop      = 1'b0;
    eras     = 1'b0;
    dat      = '0;
    run_done = 1'b0;
    bank     = '0;
    void'($urandom(90));
    repeat (5) @(posedge iclk);
    @(negedge iclk);
    ireset = 1'b0;
    for (int f = 0; f < n_frames; f++) begin
      gap = $urandom % (max_gap + 1);
      repeat (gap) @(negedge iclk);
      bank = ~bank;
      // bank may still be on offer from two frames back
      while ((res_req || res_ack) && res_ptr == bank) begin
        @(negedge iclk);
      end
      send_frame();
    end
    repeat (8) @(negedge iclk);      // last result through the pipe
    while (res_req || res_ack) begin
      @(negedge iclk);
    end
    repeat (4) @(negedge iclk);
    run_done = 1'b1;
    wait (report_done);
    if (err_cnt == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  //------------------------------------------------------------
  // consumer, four-phase side
  //------------------------------------------------------------
  initial begin
    int delay;
    res_ack = 1'b0;
    rd_addr = '0;
    @(negedge iclk);
    forever begin
      if (res_req && !res_ack) begin
        // mostly quick, now and then slow enough to force drops
        delay = (($urandom % 4) == 0) ? 5 + ($urandom % 4) : 1 + ($urandom % 3);
        repeat (delay) @(negedge iclk);
        for (int a = 0; a < `RS_N; a++) begin
          rd_addr = data_t'(a);
          @(negedge iclk);
        end
        res_ack = 1'b1;
        while (res_req) begin
          @(negedge iclk);
        end
        res_ack = 1'b0;
      end
      @(negedge iclk);
    end
  end

  // watchdog
  initial begin
    #(timeout_ns);
    $display("watchdog expired after %0d ns, the run never reached its end", timeout_ns);
    $display("Test FAILED");
    $finish;
  end

endmodule

//--- src.f
+incdir+design
design/rs_pkg.sv
design/rs_eras_syndrome_count.sv
design/rs_frame_buffer.sv
design/rs_syndrome_handoff.sv
design/rs_decoder_frontend.sv
verif/tb_clock_gen.sv
verif/rs_frontend_checker.sv
verif/rs_frontend_tb.sv

//--- Bender.yml
package:
  name: rs_decoder_frontend

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/rs_pkg.sv
      - design/rs_eras_syndrome_count.sv
      - design/rs_frame_buffer.sv
      - design/rs_syndrome_handoff.sv
      - design/rs_decoder_frontend.sv
  - target: test
    include_dirs:
      - design
    files:
      - verif/tb_clock_gen.sv
      - verif/rs_frontend_checker.sv
      - verif/rs_frontend_tb.sv
